// ==== hdl/adc_i2c_settings.svh ====
/*
 * Build-time settings for the ADC I2C master: SCL timing and bus widths.
 * Included by the packages and by any module that sizes logic from them.
 */
`ifndef ADC_I2C_SETTINGS_SVH
`define ADC_I2C_SETTINGS_SVH

// system clocks per quarter of an SCL period
// one bit takes four quarters, so 4 here gives 16 clocks per bit
// must be 2 or more so that SDA can trail an SCL edge by a clock
`define ADC_I2C_SCL_QDIV 4

// 7-bit slave address, no 10-bit addressing
`define ADC_I2C_DEV_ID_W 7

// one I2C data byte
`define ADC_I2C_BYTE_W 8

// register address sent as the first byte after the device address
`define ADC_I2C_REG_ADDR_W 8

`endif

// ==== hdl/i2c_cmd_pkg.sv ====
/*
 * Bus-level types shared by the access sequencer and the I2C byte engine:
 * the byte payload, the per-byte command flags and the engine phases.
 */
`default_nettype none

`include "adc_i2c_settings.svh"

package i2c_cmd_pkg;

	typedef logic [`ADC_I2C_BYTE_W-1:0] i2c_byte_t;

	// one command moves one byte, start and stop are optional
	// bit order from lsb: start, write, read, stop, master_ack
	typedef struct packed {
		logic master_ack;
		logic stop;
		logic read;
		logic write;
		logic start;
	} i2c_cmd_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_START,
		PH_BIT,
		PH_ACK,
		PH_STOP
	} i2c_phase_t;

endpackage

`default_nettype wire

// ==== hdl/adc_access_pkg.sv ====
/*
 * Device-access types for the register sequencer: request fields,
 * sequencer states and the byte positions within a transaction.
 */
`default_nettype none

`include "adc_i2c_settings.svh"

package adc_access_pkg;

	typedef logic [`ADC_I2C_DEV_ID_W-1:0]   dev_id_t;
	typedef logic [`ADC_I2C_REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ,
		ST_ABORT,
		ST_FINISH
	} access_state_t;

	// byte position, counted up on every finished byte
	typedef logic [2:0] access_step_t;

	localparam access_step_t STEP_DEV_ADDR  = 3'd0;
	localparam access_step_t STEP_REG_ADDR  = 3'd1;
	localparam access_step_t STEP_WR_DATA   = 3'd2;
	localparam access_step_t STEP_DEV_RD    = 3'd2;
	localparam access_step_t STEP_RD_FIRST  = 3'd3;
	localparam access_step_t STEP_RD_SECOND = 3'd4;

endpackage

`default_nettype wire

// ==== hdl/i2c_byte_engine.sv ====
/*
 * I2C bit engine: moves one byte per command, with optional (repeated) start,
 * the ack slot and optional stop. SDA is open drain, sda_oe pulls it low.
 */
`default_nettype none

`include "adc_i2c_settings.svh"

module i2c_byte_engine
	import i2c_cmd_pkg::*;
(
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire i2c_cmd_t   cmd,
	input  wire             cmd_vld,
	input  wire i2c_byte_t  wr_data,
	input  wire             sda_in,
	output i2c_byte_t       rd_data,
	output logic            byte_done,
	output logic            ack_bad,
	output logic            busy,
	output logic            scl,
	output logic            sda_oe
);

	localparam int QDIV = `ADC_I2C_SCL_QDIV;
	localparam int QW = (QDIV > 1) ? $clog2(QDIV) : 1;
	localparam logic [QW-1:0] QLAST = QW'(QDIV - 1);

	i2c_phase_t phase;
	i2c_cmd_t cmd_r;
	logic [QW-1:0] qcnt;
	logic [1:0] qidx;
	logic [2:0] bit_idx;
	i2c_byte_t tx_shift;
	logic held;
	logic q_tick;
	logic bit_end;
	logic sample;
	logic scl_mid;
	logic scl_nxt;
	logic sda_nxt;

	assign q_tick = (qcnt == QLAST);
	assign bit_end = q_tick && (qidx == 2'd3);
	// SDA is read at the end of the SCL high time
	assign sample = q_tick && (qidx == 2'd2);
	assign scl_mid = (qidx == 2'd1) || (qidx == 2'd2);
	assign busy = (phase != PH_IDLE);

	// quarter-period divider, restarts with every command
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			qcnt <= '0;
			qidx <= 2'd0;
		end else if (phase == PH_IDLE) begin
			qcnt <= '0;
			qidx <= 2'd0;
		end else if (q_tick) begin
			qcnt <= '0;
			qidx <= qidx + 2'd1;
		end else begin
			qcnt <= qcnt + QW'(1);
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			phase <= PH_IDLE;
			cmd_r <= '0;
			bit_idx <= 3'd0;
			held <= 1'b0;
			byte_done <= 1'b0;
			ack_bad <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (cmd_vld) begin
						cmd_r <= cmd;
						bit_idx <= 3'(`ADC_I2C_BYTE_W - 1);
						ack_bad <= 1'b0;
						if (cmd.start)
							phase <= PH_START;
						else if (cmd.write || cmd.read)
							phase <= PH_BIT;
						else
							phase <= PH_STOP;
					end
				end
				PH_START: begin
					if (bit_end)
						phase <= PH_BIT;
				end
				PH_BIT: begin
					if (bit_end) begin
						bit_idx <= bit_idx - 3'd1;
						if (bit_idx == 3'd0)
							phase <= PH_ACK;
					end
				end
				PH_ACK: begin
					// high in the slot means the slave did not ack
					if (sample && cmd_r.write)
						ack_bad <= sda_in;
					if (bit_end) begin
						if (cmd_r.stop) begin
							phase <= PH_STOP;
						end else begin
							// bus stays owned, SCL parked low
							phase <= PH_IDLE;
							held <= 1'b1;
							byte_done <= 1'b1;
						end
					end
				end
				PH_STOP: begin
					if (bit_end) begin
						phase <= PH_IDLE;
						held <= 1'b0;
						byte_done <= 1'b1;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// data shifter and receiver, msb first
	always_ff @(posedge sys_clk) begin
		if (phase == PH_IDLE && cmd_vld)
			tx_shift <= wr_data;
		else if (phase == PH_BIT && bit_end)
			tx_shift <= {tx_shift[`ADC_I2C_BYTE_W-2:0], 1'b0};
		if (phase == PH_BIT && sample && cmd_r.read)
			rd_data <= {rd_data[`ADC_I2C_BYTE_W-2:0], sda_in};
	end

	// line levels per phase and quarter
	always_comb begin
		scl_nxt = 1'b1;
		sda_nxt = 1'b0;
		case (phase)
			PH_IDLE: scl_nxt = !held;
			PH_START: begin
				// SDA falls while SCL is high
				scl_nxt = scl_mid;
				sda_nxt = qidx[1];
			end
			PH_BIT: begin
				scl_nxt = scl_mid;
				sda_nxt = cmd_r.write && !tx_shift[`ADC_I2C_BYTE_W-1];
			end
			PH_ACK: begin
				scl_nxt = scl_mid;
				sda_nxt = cmd_r.read && cmd_r.master_ack;
			end
			PH_STOP: begin
				// SDA goes low one clock after SCL, then rises while SCL is high
				scl_nxt = (qidx != 2'd0);
				sda_nxt = ((qidx == 2'd0) && (qcnt != '0)) || (qidx == 2'd1);
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl <= 1'b1;
			sda_oe <= 1'b0;
		end else begin
			scl <= scl_nxt;
			sda_oe <= sda_nxt;
		end
	end

	// the sequencer waits for byte_done before the next command
	a_no_cmd_when_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cmd_vld |-> !busy);

	a_cmd_dir_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cmd_vld |-> !(cmd.write && cmd.read));

endmodule

`default_nettype wire

// ==== hdl/adc_access_ctrl.sv ====
/*
 * Register access sequencer for the ADC/DAC: turns write and read requests
 * into byte commands for the I2C engine, packs read data, reports NACKs.
 */
`default_nettype none

module adc_access_ctrl
	import i2c_cmd_pkg::*, adc_access_pkg::*;
(
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire             wr_req,
	input  wire             rd_req,
	input  wire dev_id_t    device_id,
	input  wire reg_addr_t  reg_addr,
	input  wire i2c_byte_t  wr_data,
	input  wire i2c_byte_t  op_rd_data,
	input  wire             byte_done,
	input  wire             ack_bad,
	output i2c_cmd_t        cmd,
	output logic            cmd_vld,
	output i2c_byte_t       op_wr_data,
	output i2c_byte_t       rd_data,
	output logic            rd_data_vld,
	output logic            ready,
	output logic            nack_err
);

	// flags from lsb: start, write, read, stop, master_ack
	localparam i2c_cmd_t CMD_START_WR = 5'b00011;
	localparam i2c_cmd_t CMD_WR       = 5'b00010;
	localparam i2c_cmd_t CMD_WR_STOP  = 5'b01010;
	localparam i2c_cmd_t CMD_RD_ACK   = 5'b10100;
	localparam i2c_cmd_t CMD_RD_STOP  = 5'b01100;
	localparam i2c_cmd_t CMD_STOP     = 5'b01000;

	access_state_t state;
	access_step_t step;
	dev_id_t dev_id_r;
	reg_addr_t reg_addr_r;
	i2c_byte_t wr_data_r;
	i2c_byte_t rd_byte0;
	i2c_byte_t rd_byte1;
	logic accept;

	assign ready = (state == ST_IDLE);
	assign accept = ready && (wr_req || rd_req);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ST_IDLE;
			step <= STEP_DEV_ADDR;
			rd_data <= '0;
			rd_data_vld <= 1'b0;
			nack_err <= 1'b0;
		end else begin
			rd_data_vld <= 1'b0;
			nack_err <= 1'b0;
			case (state)
				ST_IDLE: begin
					step <= STEP_DEV_ADDR;
					// write wins when both arrive
					if (wr_req)
						state <= ST_WRITE;
					else if (rd_req)
						state <= ST_READ;
				end
				ST_WRITE, ST_READ: begin
					if (byte_done) begin
						step <= step + 3'd1;
						if (ack_bad)
							state <= ST_ABORT;
						else if (state == ST_WRITE && step == STEP_WR_DATA)
							state <= ST_IDLE;
						else if (state == ST_READ && step == STEP_RD_SECOND)
							state <= ST_FINISH;
					end
				end
				ST_ABORT: begin
					if (byte_done) begin
						state <= ST_IDLE;
						nack_err <= 1'b1;
					end
				end
				ST_FINISH: begin
					// low nibble of second byte above high nibble of first
					rd_data <= {rd_byte1[3:0], rd_byte0[7:4]};
					rd_data_vld <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// command strobe, one cycle after each byte_done
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cmd <= '0;
			cmd_vld <= 1'b0;
		end else begin
			cmd_vld <= 1'b0;
			if (accept) begin
				cmd_vld <= 1'b1;
				cmd <= CMD_START_WR;
			end else if (byte_done && ack_bad && (state == ST_WRITE || state == ST_READ)) begin
				cmd_vld <= 1'b1;
				cmd <= CMD_STOP;
			end else if (byte_done && state == ST_WRITE && step != STEP_WR_DATA) begin
				cmd_vld <= 1'b1;
				cmd <= (step == STEP_DEV_ADDR) ? CMD_WR : CMD_WR_STOP;
			end else if (byte_done && state == ST_READ && step != STEP_RD_SECOND) begin
				cmd_vld <= 1'b1;
				case (step)
					STEP_DEV_ADDR: cmd <= CMD_WR;
					STEP_REG_ADDR: cmd <= CMD_START_WR;
					STEP_DEV_RD:   cmd <= CMD_RD_ACK;
					default:       cmd <= CMD_RD_STOP;
				endcase
			end
		end
	end

	// request fields, outgoing byte and read bytes
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			dev_id_r <= device_id;
			reg_addr_r <= reg_addr;
			wr_data_r <= wr_data;
			op_wr_data <= {device_id, 1'b0};
		end else if (byte_done && !ack_bad) begin
			if (step == STEP_DEV_ADDR)
				op_wr_data <= reg_addr_r;
			else if (step == STEP_REG_ADDR)
				op_wr_data <= (state == ST_WRITE) ? wr_data_r : {dev_id_r, 1'b1};
		end
		if (byte_done && state == ST_READ && step == STEP_RD_FIRST)
			rd_byte0 <= op_rd_data;
		if (byte_done && state == ST_READ && step == STEP_RD_SECOND)
			rd_byte1 <= op_rd_data;
	end

	// the engine only finishes a byte while a transaction owns the bus
	a_done_in_transfer: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_done |-> (state == ST_WRITE || state == ST_READ || state == ST_ABORT));

endmodule

`default_nettype wire

// ==== hdl/adc_i2c_top.sv ====
/*
 * Top level of the ADC/DAC I2C master: register access sequencer driving
 * the byte engine. SDA leaves as an open-drain pair, sda_oe and sda_in.
 */
`default_nettype none

module adc_i2c_top
	import i2c_cmd_pkg::*, adc_access_pkg::*;
(
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire             wr_req,
	input  wire             rd_req,
	input  wire dev_id_t    device_id,
	input  wire reg_addr_t  reg_addr,
	input  wire i2c_byte_t  wr_data,
	output i2c_byte_t       rd_data,
	output logic            rd_data_vld,
	output logic            ready,
	output logic            nack_err,
	output logic            scl,
	output logic            sda_oe,
	input  wire             sda_in
);

	i2c_cmd_t cmd;
	logic cmd_vld;
	i2c_byte_t op_wr_data;
	i2c_byte_t op_rd_data;
	logic byte_done;
	logic ack_bad;

	adc_access_ctrl u_ctrl (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.wr_req      (wr_req),
		.rd_req      (rd_req),
		.device_id   (device_id),
		.reg_addr    (reg_addr),
		.wr_data     (wr_data),
		.op_rd_data  (op_rd_data),
		.byte_done   (byte_done),
		.ack_bad     (ack_bad),
		.cmd         (cmd),
		.cmd_vld     (cmd_vld),
		.op_wr_data  (op_wr_data),
		.rd_data     (rd_data),
		.rd_data_vld (rd_data_vld),
		.ready       (ready),
		.nack_err    (nack_err)
	);

	// busy is left open, the sequencer paces itself on byte_done
	i2c_byte_engine u_engine (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cmd       (cmd),
		.cmd_vld   (cmd_vld),
		.wr_data   (op_wr_data),
		.sda_in    (sda_in),
		.rd_data   (op_rd_data),
		.byte_done (byte_done),
		.ack_bad   (ack_bad),
		.busy      (),
		.scl       (scl),
		.sda_oe    (sda_oe)
	);

endmodule

`default_nettype wire

// ==== verification/adc_slave_model.sv ====
/*
 * Behavioral I2C slave for the testbench. Holds a 256-byte register file.
 * The first byte after the address sets the register pointer, which then
 * counts up on every data byte in either direction.
 */
`default_nettype none

module adc_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h54
) (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  wire  scl,
	input  wire  sda,
	output logic sda_pull
);

	logic [7:0] regs [0:255];
	logic [7:0] shift;
	logic [7:0] ptr;
	logic [3:0] bit_cnt;
	logic [1:0] byte_idx;
	logic scl_q;
	logic sda_q;
	logic active;
	logic in_ack;
	logic rw;
	logic reading;
	logic mack;

	// bus sampled every system clock, edges found against the last sample
	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < 256; i++)
				regs[8'(i)] <= {i[3:0], i[7:4]} ^ 8'ha5;
			shift <= 8'h00;
			ptr <= 8'h00;
			bit_cnt <= 4'd0;
			byte_idx <= 2'd0;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			active <= 1'b0;
			in_ack <= 1'b0;
			rw <= 1'b0;
			reading <= 1'b0;
			mack <= 1'b0;
			sda_pull <= 1'b0;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin
				// start or repeated start, pointer is kept
				active <= 1'b1;
				in_ack <= 1'b0;
				rw <= 1'b0;
				reading <= 1'b0;
				bit_cnt <= 4'd0;
				byte_idx <= 2'd0;
				sda_pull <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin
				active <= 1'b0;
				sda_pull <= 1'b0;
			end else if (active && scl && !scl_q) begin
				if (in_ack) begin
					// low means the master wants another byte
					mack <= !sda;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					if (!reading)
						shift <= {shift[6:0], sda};
				end
			end else if (active && !scl && scl_q) begin
				if (in_ack) begin
					in_ack <= 1'b0;
					bit_cnt <= 4'd0;
					if (rw && (!reading || mack)) begin
						reading <= 1'b1;
						shift <= regs[ptr];
						sda_pull <= !regs[ptr][7];
						ptr <= ptr + 8'd1;
					end else begin
						sda_pull <= 1'b0;
						if (reading)
							active <= 1'b0;
					end
				end else if (bit_cnt == 4'd8) begin
					in_ack <= 1'b1;
					sda_pull <= !reading;
					if (!reading) begin
						if (byte_idx != 2'd2)
							byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'd0) begin
							if (shift[7:1] == DEV_ADDR) begin
								rw <= shift[0];
							end else begin
								// not our address, leave the slot high
								sda_pull <= 1'b0;
								active <= 1'b0;
							end
						end else if (byte_idx == 2'd1) begin
							ptr <= shift;
						end else begin
							regs[ptr] <= shift;
							ptr <= ptr + 8'd1;
						end
					end
				end else if (reading) begin
					sda_pull <= !shift[6];
					shift <= {shift[6:0], 1'b0};
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_adc_i2c.sv ====
/*
 * Testbench for the ADC I2C master. Runs directed and random register
 * accesses against the behavioral slave and checks every result against
 * a shadow copy of the slave's register file.
 */
`default_nettype none

`include "adc_i2c_settings.svh"

module tb_adc_i2c;

	localparam logic [6:0] SLAVE_ID = 7'h54;
	localparam int CLK_PERIOD = 20;
	localparam int BIT_CLKS = 4 * `ADC_I2C_SCL_QDIV;
	// a read is the longest transaction, under 50 bit times
	localparam int TRANS_CLKS = 60 * BIT_CLKS;
	localparam int NUM_TRANS = 30;

	logic sys_clk;
	logic sys_rst_n;
	logic wr_req;
	logic rd_req;
	logic [6:0] device_id;
	logic [7:0] reg_addr;
	logic [7:0] wr_data;
	logic [7:0] rd_data;
	logic rd_data_vld;
	logic ready;
	logic nack_err;
	logic scl;
	logic sda_oe;
	logic sda_line;
	logic slave_pull;

	logic [7:0] shadow [0:255];
	logic [31:0] rng;

	// open-drain SDA with pull-up
	assign sda_line = !(sda_oe || slave_pull);

	adc_i2c_top UUT (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.wr_req      (wr_req),
		.rd_req      (rd_req),
		.device_id   (device_id),
		.reg_addr    (reg_addr),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.rd_data_vld (rd_data_vld),
		.ready       (ready),
		.nack_err    (nack_err),
		.scl         (scl),
		.sda_oe      (sda_oe),
		.sda_in      (sda_line)
	);

	adc_slave_model #(.DEV_ADDR(SLAVE_ID)) u_slave (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.scl       (scl),
		.sda       (sda_line),
		.sda_pull  (slave_pull)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = !sys_clk;
	end

	initial begin
		#((NUM_TRANS * TRANS_CLKS + 2000) * CLK_PERIOD);
		$display("timeout: the tests did not finish in the expected time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// slave register contents after reset
	function automatic logic [7:0] fill_byte(input logic [7:0] addr);
		return {addr[3:0], addr[7:4]} ^ 8'ha5;
	endfunction

	// low nibble of the next register above high nibble of this one
	function automatic logic [7:0] packed_read(input logic [7:0] addr);
		logic [7:0] next_addr;
		next_addr = addr + 8'd1;
		return {shadow[next_addr][3:0], shadow[addr][7:4]};
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	// one-cycle request, then confirm that it was taken
	task automatic issue_req(input logic is_wr, input logic [6:0] dev,
			input logic [7:0] addr, input logic [7:0] data);
		@(posedge sys_clk);
		wr_req <= is_wr;
		rd_req <= !is_wr;
		device_id <= dev;
		reg_addr <= addr;
		wr_data <= data;
		@(posedge sys_clk);
		check_val("ready", 32'(ready), 1);
		wr_req <= 1'b0;
		rd_req <= 1'b0;
		@(posedge sys_clk);
		check_val("ready", 32'(ready), 0);
	endtask

	// wait for ready to return, counting end pulses on the way
	task automatic wait_done(output int vld_cnt, output int nack_cnt);
		int cycles;
		cycles = 0;
		vld_cnt = 0;
		nack_cnt = 0;
		do begin
			@(posedge sys_clk);
			cycles++;
			if (rd_data_vld)
				vld_cnt++;
			if (nack_err)
				nack_cnt++;
			if (cycles > TRANS_CLKS)
				fail_run("ready did not come back within one transaction time");
		end while (!ready);
		// pulses last one cycle and nothing new starts
		@(posedge sys_clk);
		check_val("rd_data_vld", 32'(rd_data_vld), 0);
		check_val("nack_err", 32'(nack_err), 0);
		check_val("ready", 32'(ready), 1);
	endtask

	task automatic reg_write(input logic [6:0] dev, input logic [7:0] addr,
			input logic [7:0] data);
		int vld_cnt;
		int nack_cnt;
		issue_req(1'b1, dev, addr, data);
		wait_done(vld_cnt, nack_cnt);
		check_val("rd_data_vld pulses", vld_cnt, 0);
		check_val("nack_err pulses", nack_cnt, (dev == SLAVE_ID) ? 0 : 1);
		if (dev == SLAVE_ID)
			shadow[addr] = data;
	endtask

	task automatic reg_read(input logic [6:0] dev, input logic [7:0] addr);
		int vld_cnt;
		int nack_cnt;
		logic [7:0] prev;
		prev = rd_data;
		issue_req(1'b0, dev, addr, 8'h00);
		wait_done(vld_cnt, nack_cnt);
		if (dev == SLAVE_ID) begin
			check_val("rd_data_vld pulses", vld_cnt, 1);
			check_val("nack_err pulses", nack_cnt, 0);
			check_val("rd_data", 32'(rd_data), 32'(packed_read(addr)));
		end else begin
			check_val("rd_data_vld pulses", vld_cnt, 0);
			check_val("nack_err pulses", nack_cnt, 1);
			check_val("rd_data", 32'(rd_data), 32'(prev));
		end
	endtask

	task automatic test_reset_state();
		repeat (10) begin
			@(posedge sys_clk);
			check_val("ready", 32'(ready), 1);
			check_val("scl", 32'(scl), 1);
			check_val("sda_oe", 32'(sda_oe), 0);
			check_val("rd_data_vld", 32'(rd_data_vld), 0);
			check_val("nack_err", 32'(nack_err), 0);
		end
	endtask

	task automatic test_write_read();
		reg_write(SLAVE_ID, 8'h10, 8'h3c);
		reg_write(SLAVE_ID, 8'h11, 8'hd2);
		reg_read(SLAVE_ID, 8'h10);
		// second read byte wraps to register 0
		reg_write(SLAVE_ID, 8'hff, 8'h96);
		reg_read(SLAVE_ID, 8'hff);
	endtask

	task automatic test_random();
		logic [31:0] r;
		for (int i = 0; i < 20; i++) begin
			rng = xorshift32(rng);
			r = rng;
			if (r[0])
				reg_write(SLAVE_ID, r[15:8], r[23:16]);
			else
				reg_read(SLAVE_ID, r[15:8]);
		end
	endtask

	task automatic test_wrong_device();
		reg_read(7'h55, 8'h10);
		// inverted data so a stray write would show in the read back
		reg_write(7'h55, 8'h10, ~shadow[8'h10]);
		reg_read(SLAVE_ID, 8'h10);
	endtask

	task automatic test_busy_request();
		int vld_cnt;
		int nack_cnt;
		issue_req(1'b1, SLAVE_ID, 8'h40, 8'h5e);
		repeat (BIT_CLKS) @(posedge sys_clk);
		wr_req <= 1'b1;
		reg_addr <= 8'h41;
		wr_data <= ~shadow[8'h41];
		@(posedge sys_clk);
		check_val("ready", 32'(ready), 0);
		wr_req <= 1'b0;
		wait_done(vld_cnt, nack_cnt);
		check_val("rd_data_vld pulses", vld_cnt, 0);
		check_val("nack_err pulses", nack_cnt, 0);
		shadow[8'h40] = 8'h5e;
		// register 0x41 keeps its old value
		reg_read(SLAVE_ID, 8'h40);
	endtask

	initial begin
		rng = 32'd10;
		for (int i = 0; i < 256; i++)
			shadow[8'(i)] = fill_byte(8'(i));
		sys_rst_n <= 1'b0;
		wr_req <= 1'b0;
		rd_req <= 1'b0;
		device_id <= 7'h00;
		reg_addr <= 8'h00;
		wr_data <= 8'h00;
		repeat (16) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		test_reset_state();
		test_write_read();
		test_random();
		test_wrong_device();
		test_busy_request();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/i2c_cmd_pkg.sv
hdl/adc_access_pkg.sv
hdl/i2c_byte_engine.sv
hdl/adc_access_ctrl.sv
hdl/adc_i2c_top.sv
verification/adc_slave_model.sv
verification/tb_adc_i2c.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ADC I2C testbench with Verilator, run it, look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_adc_i2c -f flist.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
